//--- Makefile
VERILATOR  := verilator
TOP        := prefetcher_tb
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert --timescale 1ns/1ps --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status of the simulation is the test result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- include/prefetch_macros.svh
// --------------------------------------------------
// Prefetcher widths, buffer geometry, reserved tags
// --------------------------------------------------
`ifndef PREFETCH_MACROS_SVH
`define PREFETCH_MACROS_SVH

// Bus field widths
`define PF_ADDR_W 32
`define PF_TID_W 4
`define PF_LEN_W 8
`define PF_DATA_W 64

// One block is one data beat
`define PF_BLOCK_BYTES 8

// Entries in the block buffer, power of two
`define PF_DEPTH 4

// Tags owned by the prefetcher on the memory side
`define PF_DEMAND_TID 4'hE
`define PF_FETCH_TID 4'hF

`endif

//--- rtl/axi_chan_pkg.sv
// --------------------------------------------------
// AXI channel field types and payload structs
// --------------------------------------------------
`default_nettype none

`include "prefetch_macros.svh"

package axi_chan_pkg;

    typedef logic [`PF_ADDR_W-1:0] addr_t;
    typedef logic [`PF_TID_W-1:0]  tid_t;
    typedef logic [`PF_LEN_W-1:0]  len_t;
    typedef logic [`PF_DATA_W-1:0] data_t;

    // Read address channel
    typedef struct packed {
        addr_t addr;
        len_t  len;
        tid_t  id;
    } ar_chan_t;

    // Read data channel
    typedef struct packed {
        data_t data;
        tid_t  id;
        logic  last;
    } r_chan_t;

    // Write address channel, only what the gate needs
    typedef struct packed {
        addr_t addr;
        tid_t  id;
    } aw_chan_t;

endpackage

`default_nettype wire

//--- rtl/axi_path_steer.sv
// --------------------------------------------------
// Window check, AR/R path steering, AW gate, flush
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_macros.svh"

module axi_path_steer
    import axi_chan_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  addr_t    bar,
    input  addr_t    limit,
    input  logic     s_ar_valid,
    output logic     s_ar_ready,
    input  ar_chan_t s_ar,
    output logic     m_ar_valid,
    input  logic     m_ar_ready,
    output ar_chan_t m_ar,
    output logic     s_r_valid,
    input  logic     s_r_ready,
    output r_chan_t  s_r,
    input  logic     m_r_valid,
    output logic     m_r_ready,
    input  r_chan_t  m_r,
    input  logic     s_aw_valid,
    output logic     s_aw_ready,
    input  aw_chan_t s_aw,
    output logic     m_aw_valid,
    input  logic     m_aw_ready,
    output aw_chan_t m_aw,
    output logic     pf_s_ar_valid,
    input  logic     pf_s_ar_ready,
    output ar_chan_t pf_s_ar,
    input  logic     pf_m_ar_valid,
    output logic     pf_m_ar_ready,
    input  ar_chan_t pf_m_ar,
    output logic     pf_m_r_valid,
    input  logic     pf_m_r_ready,
    output r_chan_t  pf_m_r,
    input  logic     pf_s_r_valid,
    output logic     pf_s_r_ready,
    input  r_chan_t  pf_s_r,
    input  logic     outstanding,
    output logic     flush
);

    logic ar_in_win, aw_in_win, r_to_pf, aw_hold, aw_blocked;

    // Single-beat reads inside [bar, limit] belong to the prefetcher
    assign ar_in_win = (s_ar.addr >= bar) && (s_ar.addr <= limit) && (s_ar.len == '0);
    assign aw_in_win = (s_aw.addr >= bar) && (s_aw.addr <= limit);
    assign r_to_pf   = (m_r.id == `PF_DEMAND_TID) || (m_r.id == `PF_FETCH_TID);

    // AR: controller requests get the memory port first
    assign pf_s_ar_valid = s_ar_valid && ar_in_win;
    assign pf_s_ar       = s_ar;
    assign pf_m_ar_ready = m_ar_ready;
    assign m_ar_valid    = pf_m_ar_valid || (s_ar_valid && !ar_in_win);
    assign m_ar          = pf_m_ar_valid ? pf_m_ar : s_ar;
    assign s_ar_ready    = ar_in_win ? pf_s_ar_ready : (m_ar_ready && !pf_m_ar_valid);

    // R: reserved tags to the controller, controller reply wins toward master
    assign pf_m_r_valid = m_r_valid && r_to_pf;
    assign pf_m_r       = m_r;
    assign pf_s_r_ready = s_r_ready;
    assign s_r_valid    = pf_s_r_valid || (m_r_valid && !r_to_pf);
    assign s_r          = pf_s_r_valid ? pf_s_r : m_r;
    assign m_r_ready    = r_to_pf ? pf_m_r_ready : (s_r_ready && !pf_s_r_valid);

    // AW waits in the window until all fills have drained
    assign aw_hold    = s_aw_valid && aw_in_win && outstanding;
    assign m_aw_valid = s_aw_valid && !aw_hold;
    assign m_aw       = s_aw;
    assign s_aw_ready = m_aw_ready && !aw_hold;
    assign flush      = s_aw_valid && aw_in_win && !aw_blocked;   // Once per AW

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            aw_blocked <= 1'b0;
        else if (s_aw_valid && s_aw_ready)
            aw_blocked <= 1'b0;
        else if (s_aw_valid && aw_in_win)
            aw_blocked <= 1'b1;
    end

    // Reserved memory tags never reach the master from either path
    a_r_no_reserved: assert property (@(posedge clk) disable iff (!arst_n)
        s_r_valid |-> (s_r.id != `PF_DEMAND_TID) && (s_r.id != `PF_FETCH_TID));

endmodule

`default_nettype wire

//--- rtl/prefetch_buffer.sv
// --------------------------------------------------
// Fully associative prefetch block buffer with
// in-order fill queue and flush
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_macros.svh"

module prefetch_buffer
    import axi_chan_pkg::*, prefetch_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        flush,
    input  lookup_req_t lookup_req,
    output lookup_rsp_t lookup_rsp,
    input  logic        alloc_valid,
    input  addr_t       alloc_addr,
    output logic        alloc_ok,
    input  logic        fill_valid,
    input  r_chan_t     fill,
    output logic        outstanding
);

    addr_t               ent_addr [`PF_DEPTH];
    data_t               ent_data [`PF_DEPTH];
    logic [`PF_DEPTH-1:0] ent_valid;
    logic [`PF_DEPTH-1:0] ent_pend;

    slot_t fill_q [`PF_DEPTH];   // Slots waiting for data, oldest at rd_ptr
    slot_t rd_ptr, wr_ptr;
    cnt_t  q_cnt;
    cnt_t  orphan_cnt;           // Reads whose entry was flushed
    slot_t free_slot, hit_slot, head_slot;
    logic  any_free;
    logic  fill_pop;

    assign head_slot   = fill_q[rd_ptr];
    assign fill_pop    = fill_valid && (orphan_cnt == '0);
    assign alloc_ok    = any_free && (orphan_cnt == '0);
    assign outstanding = (|ent_pend) || (orphan_cnt != '0);

    // Lowest free entry wins
    always_comb begin
        free_slot = '0;
        any_free  = 1'b0;
        for (int i = `PF_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i] && !ent_pend[i]) begin
                free_slot = slot_t'(i);
                any_free  = 1'b1;
            end
        end
    end

    always_comb begin
        lookup_rsp = '0;
        hit_slot   = '0;
        for (int i = 0; i < `PF_DEPTH; i++) begin
            if (ent_valid[i] && (ent_addr[i] == lookup_req.addr)) begin
                lookup_rsp.hit  = 1'b1;
                lookup_rsp.data = ent_data[i];
                hit_slot        = slot_t'(i);
            end
            if (ent_pend[i] && (ent_addr[i] == lookup_req.addr))
                lookup_rsp.pending = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ent_valid  <= '0;
            ent_pend   <= '0;
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            q_cnt      <= '0;
            orphan_cnt <= '0;
        end else if (flush) begin
            ent_valid  <= '0;
            ent_pend   <= '0;
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            q_cnt      <= '0;
            // Everything still in flight now returns to nobody
            orphan_cnt <= orphan_cnt + q_cnt - cnt_t'(fill_valid);
        end else begin
            if (lookup_req.valid && lookup_rsp.hit)
                ent_valid[hit_slot] <= 1'b0;   // Consumed by the reply
            if (alloc_valid) begin
                ent_pend[free_slot] <= 1'b1;
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fill_valid && !fill_pop)
                orphan_cnt <= orphan_cnt - 1'b1;
            if (fill_pop) begin
                ent_pend[head_slot]  <= 1'b0;
                ent_valid[head_slot] <= 1'b1;
                rd_ptr <= rd_ptr + 1'b1;
            end
            q_cnt <= q_cnt + cnt_t'(alloc_valid) - cnt_t'(fill_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            ent_addr[free_slot] <= alloc_addr;
            fill_q[wr_ptr]      <= free_slot;
        end
        if (fill_pop)
            ent_data[head_slot] <= fill.data;
    end

    a_alloc_ok: assert property (@(posedge clk) disable iff (!arst_n)
        alloc_valid |-> alloc_ok && !flush);

    // A fill beat must match a read the buffer still counts
    a_fill_owned: assert property (@(posedge clk) disable iff (!arst_n)
        fill_valid |-> (q_cnt != '0) || (orphan_cnt != '0));

endmodule

`default_nettype wire

//--- rtl/prefetch_ctrl.sv
// --------------------------------------------------
// Prefetch controller: window read FSM, demand and
// next-block fetch issue, reply to the master
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_macros.svh"

module prefetch_ctrl
    import axi_chan_pkg::*, prefetch_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        flush,
    input  logic        pf_s_ar_valid,
    output logic        pf_s_ar_ready,
    input  ar_chan_t    pf_s_ar,
    output logic        pf_m_ar_valid,
    input  logic        pf_m_ar_ready,
    output ar_chan_t    pf_m_ar,
    input  logic        pf_m_r_valid,
    output logic        pf_m_r_ready,
    input  r_chan_t     pf_m_r,
    output logic        pf_s_r_valid,
    input  logic        pf_s_r_ready,
    output r_chan_t     pf_s_r,
    output lookup_req_t lookup_req,
    input  lookup_rsp_t lookup_rsp,
    output logic        alloc_valid,
    output addr_t       alloc_addr,
    input  logic        alloc_ok
);

    ctrl_state_t state, state_nxt;
    ar_chan_t    req_q;        // Accepted window read
    data_t       reply_data;
    addr_t       next_addr;
    logic        demand_beat;
    logic        fetch_miss;

    assign next_addr   = req_q.addr + addr_t'(`PF_BLOCK_BYTES);
    assign demand_beat = (state == st_demand_r) && pf_m_r_valid
                         && (pf_m_r.id == `PF_DEMAND_TID);
    assign fetch_miss  = !lookup_rsp.hit && !lookup_rsp.pending;

    // Slave side
    assign pf_s_ar_ready = (state == st_idle);
    assign pf_s_r_valid  = (state == st_reply);
    assign pf_s_r.data   = reply_data;
    assign pf_s_r.id     = req_q.id;
    assign pf_s_r.last   = 1'b1;

    // Only the demand lookup consumes; the reply state probes the next block
    assign lookup_req.valid = (state == st_lookup);
    assign lookup_req.addr  = (state == st_lookup) ? req_q.addr : next_addr;

    // Memory side
    assign pf_m_ar_valid = (state == st_demand_ar) || (state == st_fetch_ar);
    assign pf_m_ar.addr  = (state == st_fetch_ar) ? next_addr : req_q.addr;
    assign pf_m_ar.len   = '0;
    assign pf_m_ar.id    = (state == st_fetch_ar) ? `PF_FETCH_TID : `PF_DEMAND_TID;

    // Fill beats are always taken so the buffer never stalls memory
    assign pf_m_r_ready = (pf_m_r.id == `PF_FETCH_TID)
                          || ((pf_m_r.id == `PF_DEMAND_TID) && (state == st_demand_r));

    // Reserve the entry when the fetch is committed, before the read goes out
    assign alloc_valid = (state == st_reply) && pf_s_r_ready && fetch_miss
                         && alloc_ok && !flush;
    assign alloc_addr  = next_addr;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:      if (pf_s_ar_valid) state_nxt = st_lookup;
            st_lookup: begin
                if (lookup_rsp.hit)
                    state_nxt = st_reply;
                else if (!lookup_rsp.pending)
                    state_nxt = st_demand_ar;   // Pending entry: wait here for fill
            end
            st_demand_ar: if (pf_m_ar_ready) state_nxt = st_demand_r;
            st_demand_r:  if (demand_beat) state_nxt = st_reply;
            st_reply: begin
                if (pf_s_r_ready)
                    state_nxt = alloc_valid ? st_fetch_ar : st_idle;
            end
            st_fetch_ar:  if (pf_m_ar_ready) state_nxt = st_idle;
            default:      state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            state <= st_idle;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk) begin
        if (pf_s_ar_valid && pf_s_ar_ready)
            req_q <= pf_s_ar;
        if ((state == st_lookup) && lookup_rsp.hit)
            reply_data <= lookup_rsp.data;
        else if (demand_beat)
            reply_data <= pf_m_r.data;
    end

    // Memory request must hold until taken
    a_m_ar_stable: assert property (@(posedge clk) disable iff (!arst_n)
        pf_m_ar_valid && !pf_m_ar_ready |=> pf_m_ar_valid && $stable(pf_m_ar));

    a_state_legal: assert property (@(posedge clk) disable iff (!arst_n)
        state inside {st_idle, st_lookup, st_demand_ar, st_demand_r, st_reply, st_fetch_ar});

endmodule

`default_nettype wire

//--- rtl/prefetch_pkg.sv
// --------------------------------------------------
// Prefetcher internal types: FSM state, lookup ports
// --------------------------------------------------
`default_nettype none

`include "prefetch_macros.svh"

package prefetch_pkg;

    import axi_chan_pkg::*;

    typedef logic [$clog2(`PF_DEPTH)-1:0] slot_t;
    typedef logic [$clog2(`PF_DEPTH):0]   cnt_t;   // Counts 0..PF_DEPTH

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_demand_ar,
        st_demand_r,
        st_reply,
        st_fetch_ar
    } ctrl_state_t;

    // valid doubles as the consume strobe on a hit
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } lookup_req_t;

    typedef struct packed {
        logic  hit;
        logic  pending;   // Allocated, data not back yet
        data_t data;
    } lookup_rsp_t;

endpackage

`default_nettype wire

//--- rtl/prefetcher_top.sv
// --------------------------------------------------
// Prefetcher top: controller, buffer, path steering
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_macros.svh"

module prefetcher_top
    import axi_chan_pkg::*, prefetch_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  addr_t    bar,
    input  addr_t    limit,
    input  logic     s_ar_valid,
    output logic     s_ar_ready,
    input  ar_chan_t s_ar,
    output logic     s_r_valid,
    input  logic     s_r_ready,
    output r_chan_t  s_r,
    input  logic     s_aw_valid,
    output logic     s_aw_ready,
    input  aw_chan_t s_aw,
    output logic     m_ar_valid,
    input  logic     m_ar_ready,
    output ar_chan_t m_ar,
    input  logic     m_r_valid,
    output logic     m_r_ready,
    input  r_chan_t  m_r,
    output logic     m_aw_valid,
    input  logic     m_aw_ready,
    output aw_chan_t m_aw
);

    logic        flush, outstanding;
    logic        pf_s_ar_valid, pf_s_ar_ready, pf_m_ar_valid, pf_m_ar_ready;
    logic        pf_m_r_valid, pf_m_r_ready, pf_s_r_valid, pf_s_r_ready;
    ar_chan_t    pf_s_ar, pf_m_ar;
    r_chan_t     pf_m_r, pf_s_r;
    lookup_req_t lookup_req;
    lookup_rsp_t lookup_rsp;
    logic        alloc_valid, alloc_ok, fill_valid;
    addr_t       alloc_addr;

    // Fetch-tagged beats fill the buffer as the controller takes them
    assign fill_valid = pf_m_r_valid && pf_m_r_ready && (pf_m_r.id == `PF_FETCH_TID);

    axi_path_steer axi_path_steer_i (.*);

    prefetch_ctrl prefetch_ctrl_i (.*);

    prefetch_buffer prefetch_buffer_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .lookup_req  (lookup_req),
        .lookup_rsp  (lookup_rsp),
        .alloc_valid (alloc_valid),
        .alloc_addr  (alloc_addr),
        .alloc_ok    (alloc_ok),
        .fill_valid  (fill_valid),
        .fill        (pf_m_r),
        .outstanding (outstanding)
    );

endmodule

`default_nettype wire

//--- verification/mem_model.sv
// --------------------------------------------------
// Memory slave model: in-order AR queue, R beats
// computed from the address, random ready delays
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_macros.svh"

module mem_model
    import axi_chan_pkg::*;
(
    input  logic        clk,
    input  logic [31:0] bp_rnd,       // Random word, stable at negedge
    input  logic        m_ar_valid,
    output logic        m_ar_ready,
    input  ar_chan_t    m_ar,
    output logic        m_r_valid,
    input  logic        m_r_ready,
    output r_chan_t     m_r,
    output logic        m_aw_ready
);

    ar_chan_t    pend_q [$];   // Accepted reads, oldest first
    ar_chan_t    ar_s;
    int          beat;         // Beat index inside the head read
    logic        ar_fire, r_fire, hold;
    logic [31:0] rnd_s;

    // Memory contents, a hash of the full address
    function automatic data_t mem_word(input addr_t a);
        logic [31:0] h;
        h = a * 32'h9e3779b1;
        h = h ^ (h >> 15);
        return {h ^ 32'h5bd1e995, a ^ (h << 11)};
    endfunction

    initial begin
        m_ar_ready = 1'b0;
        m_r_valid  = 1'b0;
        m_r        = '0;
        m_aw_ready = 1'b0;
        beat       = 0;
    end

    always begin
        @(negedge clk);
        ar_fire = m_ar_valid && m_ar_ready;   // Transfers on the coming edge
        r_fire  = m_r_valid && m_r_ready;
        ar_s    = m_ar;
        rnd_s   = bp_rnd;
        @(posedge clk);
        #1;
        if (ar_fire)
            pend_q.push_back(ar_s);
        if (r_fire) begin
            if (m_r.last) begin
                void'(pend_q.pop_front());
                beat = 0;
            end else begin
                beat++;
            end
        end
        hold = m_r_valid && !r_fire;   // Payload stays until taken
        if (!hold) begin
            m_r_valid = (pend_q.size() != 0) && (rnd_s[1:0] != 2'b00);
            if (m_r_valid) begin
                m_r.data = mem_word(pend_q[0].addr + addr_t'(beat * `PF_BLOCK_BYTES));
                m_r.id   = pend_q[0].id;
                m_r.last = (beat == int'(pend_q[0].len));
            end
        end
        m_ar_ready = rnd_s[2] | rnd_s[3];
        m_aw_ready = rnd_s[4] | rnd_s[5];
    end

endmodule

`default_nettype wire

//--- verification/prefetcher_tb.sv
// --------------------------------------------------
// Prefetcher testbench: directed and random reads,
// write flush, scoreboard of replies and memory reads
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_macros.svh"

module prefetcher_tb
    import axi_chan_pkg::*;
();

    localparam logic [31:0] SEED    = 32'h339ab3b7;
    localparam addr_t       BAR     = 32'h0000_1000;
    localparam addr_t       LIMIT   = 32'h0000_1fff;
    localparam int          TIMEOUT = 2000;

    logic        clk = 1'b0;
    logic        arst_n;
    addr_t       bar, limit;
    logic        s_ar_valid, s_ar_ready, s_r_valid, s_r_ready, s_aw_valid, s_aw_ready;
    logic        m_ar_valid, m_ar_ready, m_r_valid, m_r_ready, m_aw_valid, m_aw_ready;
    ar_chan_t    s_ar, m_ar;
    r_chan_t     s_r, m_r;
    aw_chan_t    s_aw, m_aw;
    aw_chan_t    aw_sent;      // Last write address handed to the DUT
    logic [31:0] bp_rnd, stim_rnd;
    string       test_name;

    // Open requests, indexed by master id
    addr_t       exp_addr [16];
    len_t        exp_len [16];
    int          beat_no [16];
    logic [15:0] busy;
    int          n_req, n_rsp, n_aw, fetch_inflight;
    ar_chan_t    ar_log [$];   // Every m_ar transfer

    always #2 clk = ~clk;

    prefetcher_top prefetcher_top_i (.*);

    mem_model mem_model_i (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic int log_count(input addr_t addr, input tid_t id);
        int n;
        n = 0;
        foreach (ar_log[i])
            if ((ar_log[i].addr == addr) && (ar_log[i].id == id))
                n++;
        return n;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (exp == act) else
            abort_run($sformatf("MISMATCH %s %s expected %0h actual %0h",
                                test_name, what, exp, act));
    endtask

    task automatic wait_free(input tid_t id);
        int t;
        t = 0;
        while (busy[id]) begin
            @(posedge clk);
            #1;
            t++;
            if (t > TIMEOUT)
                abort_run($sformatf("no reply for id %0h in %s", id, test_name));
        end
    endtask

    task automatic send_read(input tid_t id, input addr_t addr, input len_t len);
        int t;
        wait_free(id);
        exp_addr[id] = addr;
        exp_len[id]  = len;
        beat_no[id]  = 0;
        busy[id]     = 1'b1;
        n_req++;
        s_ar       = '{addr: addr, len: len, id: id};
        s_ar_valid = 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT)
                abort_run("read request was never accepted");
        end while (!s_ar_ready);
        @(posedge clk);
        #1;
        s_ar_valid = 1'b0;
    endtask

    task automatic send_write(input addr_t addr);
        int t;
        aw_sent    = '{addr: addr, id: 4'h3};
        s_aw       = aw_sent;
        s_aw_valid = 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT)
                abort_run("write address was never accepted");
        end while (!s_aw_ready);
        @(posedge clk);
        #1;
        s_aw_valid = 1'b0;
    endtask

    // Idle means two quiet samples in a row, so a late fetch issue is seen
    task automatic wait_idle();
        int t, quiet;
        t     = 0;
        quiet = 0;
        while (quiet < 2) begin
            @(negedge clk);
            quiet = ((busy == '0) && (fetch_inflight == 0) && !m_ar_valid) ? quiet + 1 : 0;
            t++;
            if (t > TIMEOUT)
                abort_run($sformatf("DUT did not go idle in %s", test_name));
        end
        @(posedge clk);
        #1;
    endtask

    // Ready on the master R side
    always @(posedge clk) begin
        #1;
        bp_rnd    = xorshift(bp_rnd);
        s_r_ready = bp_rnd[9] | bp_rnd[10] | bp_rnd[11];
    end

    // Monitor, samples at negedge where every signal has settled
    always @(negedge clk) begin
        if (arst_n) begin
            if (m_aw_valid && m_aw_ready) begin
                n_aw++;
                check_eq("m_aw addr", 64'(aw_sent.addr), 64'(m_aw.addr));
                check_eq("m_aw id", 64'(aw_sent.id), 64'(m_aw.id));
                if ((m_aw.addr >= bar) && (m_aw.addr <= limit))
                    assert (fetch_inflight == 0) else
                        abort_run("window write reached memory with fetch reads in flight");
            end
            if (m_ar_valid && m_ar_ready) begin
                ar_log.push_back(m_ar);
                if (m_ar.id == `PF_FETCH_TID) begin
                    fetch_inflight++;
                end else if (m_ar.id != `PF_DEMAND_TID) begin
                    assert (busy[m_ar.id]) else
                        abort_run("direct read reached memory with no open request");
                    check_eq("m_ar addr", 64'(exp_addr[m_ar.id]), 64'(m_ar.addr));
                    check_eq("m_ar len", 64'(exp_len[m_ar.id]), 64'(m_ar.len));
                end
            end
            if (m_r_valid && m_r_ready && (m_r.id == `PF_FETCH_TID))
                fetch_inflight--;
            if (s_r_valid && s_r_ready) begin
                assert (busy[s_r.id]) else
                    abort_run($sformatf("reply with id %0h has no open request", s_r.id));
                check_eq("s_r data", mem_model_i.mem_word(exp_addr[s_r.id]
                         + addr_t'(beat_no[s_r.id] * `PF_BLOCK_BYTES)), s_r.data);
                check_eq("s_r last", 64'(beat_no[s_r.id] == int'(exp_len[s_r.id])),
                         64'(s_r.last));
                if (s_r.last) begin
                    busy[s_r.id] = 1'b0;
                    n_rsp++;
                end else begin
                    beat_no[s_r.id]++;
                end
            end
        end
    end

    initial begin
        addr_t      a;
        len_t       ln;
        logic [9:0] seq_off;
        bar        = BAR;
        limit      = LIMIT;
        arst_n     = 1'b0;
        s_ar_valid = 1'b0;
        s_ar       = '0;
        s_r_ready  = 1'b0;
        s_aw_valid = 1'b0;
        s_aw       = '0;
        aw_sent    = '0;
        bp_rnd     = SEED;
        stim_rnd   = xorshift(SEED);
        busy       = '0;
        n_req      = 0;
        n_rsp      = 0;
        n_aw       = 0;
        fetch_inflight = 0;
        seq_off    = '0;
        test_name  = "reset";
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;

        test_name = "passthrough";
        send_read(4'h1, 32'h0000_4000, 8'd0);
        send_read(4'h2, BAR + 32'h40, 8'd2);   // Burst inside the window
        wait_idle();
        check_eq("direct m_ar count", 64'(2), 64'(ar_log.size()));

        test_name = "sequential";
        a = BAR + 32'h100;
        ar_log.delete();
        for (int i = 0; i < 3; i++)
            send_read(4'h3, a + addr_t'(i * `PF_BLOCK_BYTES), 8'd0);
        wait_idle();
        check_eq("demand A", 64'(1), 64'(log_count(a, `PF_DEMAND_TID)));
        check_eq("demand A+8", 64'(0), 64'(log_count(a + 32'd8, `PF_DEMAND_TID)));
        check_eq("demand A+16", 64'(0), 64'(log_count(a + 32'd16, `PF_DEMAND_TID)));
        for (int i = 1; i < 4; i++)
            check_eq("fetch count", 64'(1),
                     64'(log_count(a + addr_t'(i * `PF_BLOCK_BYTES), `PF_FETCH_TID)));

        test_name = "reread";
        ar_log.delete();
        send_read(4'h4, a + 32'd16, 8'd0);   // Consumed by the previous hit
        wait_idle();
        check_eq("demand A+16", 64'(1), 64'(log_count(a + 32'd16, `PF_DEMAND_TID)));

        test_name = "write_flush";
        a = BAR + 32'h200;
        send_read(4'h5, a, 8'd0);
        wait_free(4'h5);
        send_write(a);   // Fetch of the next block is reserved by now
        wait_idle();
        check_eq("m_aw count", 64'(1), 64'(n_aw));
        ar_log.delete();
        send_read(4'h6, a + 32'd8, 8'd0);
        wait_idle();
        check_eq("demand after flush", 64'(1), 64'(log_count(a + 32'd8, `PF_DEMAND_TID)));

        test_name = "random";
        for (int n = 0; n < 80; n++) begin
            stim_rnd = xorshift(stim_rnd);
            ln = 8'd0;
            if (stim_rnd[4:0] == 5'd0) begin
                send_write(BAR + addr_t'({stim_rnd[15:8], 3'b000}));
            end else begin
                case (stim_rnd[6:5])
                    2'd0, 2'd1: begin
                        seq_off = seq_off + 10'd8;   // Walks forward, mostly hits
                        a = BAR + addr_t'(seq_off);
                    end
                    2'd2: begin
                        a  = 32'h0000_8000 + addr_t'({stim_rnd[15:10], 3'b000});
                        ln = len_t'(stim_rnd[14:13]);
                    end
                    default: a = BAR + addr_t'({stim_rnd[17:10], 3'b000});
                endcase
                send_read(tid_t'(n % 14), a, ln);
            end
        end
        wait_idle();
        check_eq("reply count", 64'(n_req), 64'(n_rsp));

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
rtl/axi_chan_pkg.sv
rtl/prefetch_pkg.sv
rtl/prefetch_ctrl.sv
rtl/prefetch_buffer.sv
rtl/axi_path_steer.sv
rtl/prefetcher_top.sv
verification/mem_model.sv
verification/prefetcher_tb.sv
